// File: build.f
+incdir+design
design/aluPkg.sv
design/aluOperate.sv
design/branchCompare.sv
design/executeStage.sv
tests/executeStage_props.sv
tests/executeStage_tb.sv

// File: design/aluOperate.sv
//--------------------------------------------------------------------------
// ALU result datapath
// combinational, picks one of the twelve RV32I operations from the
// operation field; unused and illegal codes give zero
//--------------------------------------------------------------------------
`include "alu_config.svh"

module aluOperate import aluPkg::*; (
	// operation field of the control word
	input  aluOp_e               op,
	// rs1/pc and rs2/immediate
	input  aluOperands_t         operands,
	// combinational result, registered one level up
	output logic [`ALU_XLEN-1:0] result
);

	// signed views of the operands
	// needed by SLT and by the arithmetic right shift
	logic signed [`ALU_XLEN-1:0] signedA;
	logic signed [`ALU_XLEN-1:0] signedB;

	// shift amount, upper bits of b are ignored as RV32I requires
	logic [`ALU_SHAMT_WIDTH-1:0] shamt;

	// signed compare for SLT
	logic                        lessSigned;

	// SLT result, zero extended to full width
	logic [`ALU_XLEN-1:0]        sltResult;

	assign signedA = operands.a;
	assign signedB = operands.b;

	// low bits only, so b = 32'hffff_ffe1 shifts by one
	assign shamt = operands.b[`ALU_SHAMT_WIDTH-1:0];

	assign lessSigned = signedA < signedB;
	assign sltResult  = {{(`ALU_XLEN-1){1'b0}}, lessSigned};

	// one flat mux on the op code
	// decoder already folded the immediate forms onto these codes
	always_comb begin
		case (op)
			// also ANDI and LUI
			opAnd: begin
				result = operands.a & operands.b;
			end
			// also ORI
			opOr: begin
				result = operands.a | operands.b;
			end
			// also AUIPC, loads, stores and ADDI
			// address generation lands here
			opAdd: begin
				result = operands.a + operands.b;
			end
			// also every branch, BEQ and BNE look at this difference
			opSub: begin
				result = operands.a - operands.b;
			end
			// SLT and SLTI
			opSlt: begin
				result = sltResult;
			end
			// logical right shift, zero fill
			opSrl: begin
				result = operands.a >> shamt;
			end
			// arithmetic right shift
			// sign bit of a fills from the top
			opSra: begin
				result = signedA >>> shamt;
			end
			// left shift, zero fill
			opSll: begin
				result = operands.a << shamt;
			end
			// also XORI
			opXor: begin
				result = operands.a ^ operands.b;
			end
			// new CSR value is a itself
			opCsrrw: begin
				result = operands.a;
			end
			// set the bits of a in the old value b
			opCsrrs: begin
				result = operands.a | operands.b;
			end
			// clear the bits of a in the old value b
			opCsrrc: begin
				result = (~operands.a) & operands.b;
			end
			// jumps and anything undecodable
			opIllegal: begin
				result = '0;
			end
			// codes 12 to 14, not produced by the decoder
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

// File: design/aluPkg.sv
//--------------------------------------------------------------------------
// execute stage types
// operation and branch encodings, control word and datapath structs
//--------------------------------------------------------------------------
`include "alu_config.svh"

package aluPkg;

	// operation field of the control word, bits [3:0]
	// codes follow the core's existing ALUctl encoding
	// codes 12 to 14 are unused and give a zero result
	typedef enum logic [3:0] {
		opAnd     = 4'd0,
		opOr      = 4'd1,
		opAdd     = 4'd2,
		opSrl     = 4'd3,
		opSra     = 4'd4,
		opSll     = 4'd5,
		// SUB also serves every branch
		opSub     = 4'd6,
		opSlt     = 4'd7,
		opXor     = 4'd8,
		opCsrrw   = 4'd9,
		opCsrrs   = 4'd10,
		opCsrrc   = 4'd11,
		// jumps carry this code, result unused
		opIllegal = 4'd15
	} aluOp_e;

	// branch field of the control word, bits [6:4]
	// brNone for every non-branch instruction
	// code 7 is unused and never taken
	typedef enum logic [2:0] {
		brNone = 3'd0,
		brEq   = 3'd1,
		brNe   = 3'd2,
		brLt   = 3'd3,
		brGe   = 3'd4,
		brLtu  = 3'd5,
		brGeu  = 3'd6
	} branchOp_e;

	// 7-bit control word from the decoder
	// branch in the high bits, op in the low bits
	typedef struct packed {
		branchOp_e branch;
		aluOp_e    op;
	} aluCtl_t;

	// operand pair
	// a is rs1 or pc, b is rs2 or the immediate
	typedef struct packed {
		logic [`ALU_XLEN-1:0] a;
		logic [`ALU_XLEN-1:0] b;
	} aluOperands_t;

	// registered output of the execute stage
	// branchEnable goes to the pc select logic
	typedef struct packed {
		logic [`ALU_XLEN-1:0] result;
		logic                 branchEnable;
	} aluResult_t;

endpackage

// File: design/alu_config.svh
//--------------------------------------------------------------------------
// execute stage configuration
// operand width and shift amount width of the RV32I ALU
//--------------------------------------------------------------------------
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// register width of RV32I
// operands, result and the output register all share it
`define ALU_XLEN 32

// shift amount width
// log2 of ALU_XLEN, so only b[4:0] reaches the shifters
`define ALU_SHAMT_WIDTH 5

`endif

// File: design/branchCompare.sv
//--------------------------------------------------------------------------
// branch condition
// combinational taken flag for the six RV32I conditional branches
//--------------------------------------------------------------------------
`include "alu_config.svh"

module branchCompare import aluPkg::*; (
	// branch field of the control word
	input  branchOp_e            branch,
	// rs1 and rs2 of the branch
	input  aluOperands_t         operands,
	// ALU result, a - b during a branch
	input  logic [`ALU_XLEN-1:0] result,
	// high when the branch is taken
	output logic                 taken
);

	// zero test on the ALU difference, shared by BEQ and BNE
	logic resultZero;

	// direct operand compares for the ordering branches
	logic lessSigned;
	logic lessUnsigned;

	assign resultZero   = result == '0;
	assign lessSigned   = $signed(operands.a) < $signed(operands.b);
	assign lessUnsigned = operands.a < operands.b;

	always_comb begin
		case (branch)
			// equal when a - b is zero
			brEq: begin
				taken = resultZero;
			end
			brNe: begin
				taken = !resultZero;
			end
			// signed ordering
			brLt: begin
				taken = lessSigned;
			end
			brGe: begin
				taken = !lessSigned;
			end
			// unsigned ordering
			brLtu: begin
				taken = lessUnsigned;
			end
			brGeu: begin
				taken = !lessUnsigned;
			end
			// brNone and unused code 7
			default: begin
				taken = 1'b0;
			end
		endcase
	end

endmodule

// File: design/executeStage.sv
//--------------------------------------------------------------------------
// execute stage
// ALU result and branch flag, registered at the execute stage boundary
// one operation per cycle, one cycle of latency
//--------------------------------------------------------------------------
`include "alu_config.svh"

module executeStage import aluPkg::*; (
	input  logic         clk,
	// synchronous, active high
	input  logic         reset,
	// decoded control word, sampled every rising edge
	input  aluCtl_t      ctl,
	// operand pair, sampled with ctl
	input  aluOperands_t operands,
	// result and branch flag one cycle after the inputs
	output aluResult_t   out
);

	// control word fields
	aluOp_e               opField;
	branchOp_e            branchField;

	// combinational outputs of the two units
	logic [`ALU_XLEN-1:0] aluResult;
	logic                 branchTaken;

	// value loaded into the output register
	aluResult_t           nextOut;

	// split the control word
	assign opField     = ctl.op;
	assign branchField = ctl.branch;

	// result datapath
	aluOperate uAluOperate (
		.op       (opField),
		.operands (operands),
		.result   (aluResult)
	);

	// branch flag
	// BEQ and BNE depend on aluResult, so this sits after the ALU
	branchCompare uBranchCompare (
		.branch   (branchField),
		.operands (operands),
		.result   (aluResult),
		.taken    (branchTaken)
	);

	// pack both outputs for the stage register
	always_comb begin
		nextOut.result       = aluResult;
		nextOut.branchEnable = branchTaken;
	end

	// stage boundary register
	// cleared in reset so no branch is taken out of reset
	always_ff @(posedge clk) begin
		if (reset) begin
			out <= '0;
		end else begin
			out <= nextOut;
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# builds the execute stage testbench with Verilator and runs it into sim.log
# the run fails when the log holds the fail message or has no verdict
rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps -f build.f \
	--top-module executeStage_tb -o simv > build.log 2>&1 \
	|| { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log \
	|| { echo "simulation ended without a verdict"; exit 1; }
exit 0

// File: tests/executeStage_props.sv
//--------------------------------------------------------------------------
// execute stage properties
// reset, illegal op and branch flag rules on the registered output
//--------------------------------------------------------------------------

module executeStage_props import aluPkg::*; (
	input logic       clk,
	input logic       reset,
	input aluCtl_t    ctl,
	input aluResult_t out
);

	timeunit 1ns;
	timeprecision 1ps;

	// every reset edge clears the whole stage register
	resetClears: assert property (
		@(posedge clk) reset |=> out == '0
	) else $error("output register not cleared one cycle after reset");

	// jumps carry the illegal code and must leave nothing behind
	illegalGivesZero: assert property (
		@(posedge clk) disable iff (reset)
		(ctl.op == opIllegal && ctl.branch == brNone) |=> out == '0
	) else $error("illegal op with no branch gave a nonzero output");

	// non-branch instructions never redirect the pc
	noneNotTaken: assert property (
		@(posedge clk) disable iff (reset)
		ctl.branch == brNone |=> !out.branchEnable
	) else $error("branch flag set one cycle after a non-branch control word");

endmodule

// attached to every executeStage instance
bind executeStage executeStage_props uProps (
	.clk   (clk),
	.reset (reset),
	.ctl   (ctl),
	.out   (out)
);

// File: tests/executeStage_tb.sv
//--------------------------------------------------------------------------
// execute stage testbench
// directed tests of all ALU operations and branch tests against a
// reference model, one operation per cycle, with a cycle timeout
//--------------------------------------------------------------------------
`include "alu_config.svh"

module executeStage_tb import aluPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// reset 6, logic and arithmetic 330, compare and shifts 42,
	// CSR and illegal 13, branches 48, back to back 100
	localparam int estimatedCycles = 550;
	localparam int cycleLimit      = 4 * estimatedCycles;

	logic         clk;
	logic         reset;
	aluCtl_t      ctl;
	aluOperands_t operands;
	aluResult_t   out;

	int           errors;
	int           checks;
	int           cycles;
	logic [31:0]  rngState;

	executeStage dut (
		.clk      (clk),
		.reset    (reset),
		.ctl      (ctl),
		.operands (operands),
		.out      (out)
	);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// ends a hung run
	initial begin
		cycles = 0;
		while (cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: tests still running after %0d cycles", cycles);
		$display("Simulation FAILED");
		$finish;
	end

	// xorshift32
	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	// branch in bits [6:4], op in bits [3:0]
	function automatic aluCtl_t makeCtl(input logic [2:0] br, input logic [3:0] op);
		return aluCtl_t'({br, op});
	endfunction

	// expected stage output for one control word and operand pair
	function automatic aluResult_t modelOut(input logic [6:0] ctlBits,
			input logic [`ALU_XLEN-1:0] a, input logic [`ALU_XLEN-1:0] b);
		logic [3:0]                  op;
		logic [2:0]                  br;
		logic [`ALU_XLEN:0]          diff;
		logic                        signedLess;
		logic                        unsignedLess;
		logic [`ALU_SHAMT_WIDTH-1:0] amount;
		logic [`ALU_XLEN-1:0]        fill;
		logic [`ALU_XLEN-1:0]        r;
		aluResult_t                  m;
		op = ctlBits[3:0];
		br = ctlBits[6:4];
		amount = b[`ALU_SHAMT_WIDTH-1:0];
		// borrow of a 33-bit subtract is the unsigned compare
		diff = {1'b0, a} - {1'b0, b};
		unsignedLess = diff[`ALU_XLEN];
		// different signs: the negative one is smaller
		if (a[`ALU_XLEN-1] != b[`ALU_XLEN-1]) begin
			signedLess = a[`ALU_XLEN-1];
		end else begin
			signedLess = diff[`ALU_XLEN-1];
		end
		// ones shifted in from the top for a negative SRA
		fill = ~({`ALU_XLEN{1'b1}} >> amount);
		case (op)
			opAnd:   r = a & b;
			opOr:    r = a | b;
			opAdd:   r = a + b;
			opSub:   r = diff[`ALU_XLEN-1:0];
			opSlt:   r = signedLess ? `ALU_XLEN'(1) : `ALU_XLEN'(0);
			opSrl:   r = a >> amount;
			opSra:   r = (a >> amount) | (a[`ALU_XLEN-1] ? fill : {`ALU_XLEN{1'b0}});
			opSll:   r = a << amount;
			opXor:   r = a ^ b;
			opCsrrw: r = a;
			opCsrrs: r = b | a;
			opCsrrc: r = b & ~a;
			default: r = {`ALU_XLEN{1'b0}};
		endcase
		m.result = r;
		case (br)
			// BEQ and BNE look at the unit's own result
			brEq:    m.branchEnable = (r == {`ALU_XLEN{1'b0}});
			brNe:    m.branchEnable = (r != {`ALU_XLEN{1'b0}});
			brLt:    m.branchEnable = signedLess;
			brGe:    m.branchEnable = !signedLess;
			brLtu:   m.branchEnable = unsignedLess;
			brGeu:   m.branchEnable = !unsignedLess;
			default: m.branchEnable = 1'b0;
		endcase
		return m;
	endfunction

	task automatic checkOut(input string name, input aluResult_t expected);
		checks++;
		assert (out === expected) else begin
			errors++;
			$display("[FAIL] %s: expected result=%h taken=%b, actual result=%h taken=%b",
				name, expected.result, expected.branchEnable, out.result, out.branchEnable);
		end
	endtask

	// called on a falling edge, returns on the falling edge after the check
	task automatic applyOp(input string name, input logic [2:0] br, input logic [3:0] op,
			input logic [`ALU_XLEN-1:0] a, input logic [`ALU_XLEN-1:0] b);
		ctl = makeCtl(br, op);
		operands.a = a;
		operands.b = b;
		@(posedge clk);
		@(negedge clk);
		checkOut(name, modelOut({br, op}, a, b));
	endtask

	// nonzero inputs during reset, so a missed clear shows up
	task automatic holdReset();
		reset = 1'b1;
		ctl = makeCtl(brNe, opAdd);
		operands.a = 32'h1234_5678;
		operands.b = 32'h0000_0001;
		repeat (5) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic resetValueTest();
		checkOut("afterReset", '0);
		reset = 1'b0;
		applyOp("afterReset", brNone, opIllegal, 32'hffff_ffff, 32'h0000_0001);
	endtask

	task automatic logicArithTest();
		logic [3:0]  ops [5];
		logic [31:0] edgeVals [4];
		ops = '{opAnd, opOr, opXor, opAdd, opSub};
		// all ones plus one wraps to zero, and zero minus one wraps the other way
		edgeVals = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h0000_0001};
		for (int k = 0; k < 5; k++) begin
			for (int i = 0; i < 4; i++) begin
				for (int j = 0; j < 4; j++) begin
					applyOp($sformatf("logicArith op %0d edge", ops[k]), brNone, ops[k],
						edgeVals[i], edgeVals[j]);
				end
			end
			for (int n = 0; n < 50; n++) begin
				applyOp($sformatf("logicArith op %0d random", ops[k]), brNone, ops[k],
					nextRandom(), nextRandom());
			end
		end
	endtask

	task automatic compareShiftTest();
		logic [31:0] sltA [6];
		logic [31:0] sltB [6];
		logic [31:0] shiftA [2];
		logic [31:0] amounts [6];
		logic [3:0]  shifts [3];
		sltA = '{32'hffff_ffff, 32'h0000_0001, 32'h8000_0000, 32'h7fff_ffff, 32'h5, 32'hffff_fffd};
		sltB = '{32'h0000_0001, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000, 32'h5, 32'hffff_fffe};
		for (int i = 0; i < 6; i++) begin
			applyOp("slt", brNone, opSlt, sltA[i], sltB[i]);
		end
		shiftA = '{32'h8000_0001, 32'h70f0_1234};
		// upper bits of b set, only b[4:0] may count
		amounts = '{32'h0, 32'h1f, 32'h1, 32'hffff_ffe1, 32'h0000_0020, 32'h8000_001f};
		shifts = '{opSrl, opSra, opSll};
		for (int k = 0; k < 3; k++) begin
			for (int i = 0; i < 2; i++) begin
				for (int j = 0; j < 6; j++) begin
					applyOp($sformatf("shift op %0d", shifts[k]), brNone, shifts[k],
						shiftA[i], amounts[j]);
				end
			end
		end
	endtask

	task automatic csrIllegalTest();
		logic [31:0] csrA [3];
		logic [31:0] csrB [3];
		logic [3:0]  csrOps [3];
		logic [3:0]  badCodes [4];
		csrA = '{32'h0000_00ff, 32'hffff_ffff, 32'h0000_0000};
		csrB = '{32'h1234_5678, 32'ha5a5_a5a5, 32'hc001_d00d};
		csrOps = '{opCsrrw, opCsrrs, opCsrrc};
		for (int k = 0; k < 3; k++) begin
			for (int i = 0; i < 3; i++) begin
				applyOp($sformatf("csr op %0d", csrOps[k]), brNone, csrOps[k], csrA[i], csrB[i]);
			end
		end
		badCodes = '{4'd12, 4'd13, 4'd14, opIllegal};
		for (int i = 0; i < 4; i++) begin
			applyOp($sformatf("illegal op %0d", badCodes[i]), brNone, badCodes[i],
				nextRandom(), nextRandom());
		end
	endtask

	// every branch code against SUB, including NONE and unused code 7
	task automatic branchTest();
		logic [31:0] brA [6];
		logic [31:0] brB [6];
		brA = '{32'h5, 32'hffff_fffe, 32'h3, 32'h1, 32'h8000_0000, 32'h8000_0000};
		brB = '{32'h5, 32'h3, 32'hffff_fffe, 32'h2, 32'h1, 32'h8000_0000};
		for (int c = 0; c < 8; c++) begin
			for (int i = 0; i < 6; i++) begin
				applyOp($sformatf("branch code %0d", c), 3'(c), opSub, brA[i], brB[i]);
			end
		end
	endtask

	// fresh random control word each cycle, previous result checked first
	task automatic backToBackTest();
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] b;
		for (int n = 0; n < 100; n++) begin
			r = nextRandom();
			a = nextRandom();
			b = nextRandom();
			// equal operands now and then, so BEQ gets taken
			if (r[8:7] == 2'b00) begin
				b = a;
			end
			applyOp($sformatf("backToBack cycle %0d", n), r[6:4], r[3:0], a, b);
		end
	endtask

	initial begin
		errors = 0;
		checks = 0;
		rngState = 32'hee8d_93cd;
		reset = 1'b1;
		ctl = makeCtl(brNone, opAnd);
		operands = '0;
		holdReset();
		resetValueTest();
		logicArithTest();
		compareShiftTest();
		csrIllegalTest();
		branchTest();
		backToBackTest();
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
